// File: dv/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Everything the decode stage registers for one instruction
typedef struct packed {
	mips_pkg::id2ex_t       id;
	mips_pkg::reg_operand_t op1;
	mips_pkg::reg_operand_t op2;
} decode_expect_t;

// Reset and clear state of the decode output
function automatic decode_expect_t bubble_expect();
	decode_expect_t e;
	e = '0;
	e.id.alu_opt    = `ALU_OPT_DISABLE;
	e.id.alu_src    = `ALU_SRC_REG;
	e.id.mem_opt    = `MEM_OPT_NONE;
	e.id.branch_opt = `BRANCH_NONE;
	e.id.exc_code   = `EC_NONE;
	return e;
endfunction

function automatic logic [`MIPS_CP0_REG_W-1:0] cp0_number(input logic [4:0] rd);
	case (rd)
		5'd0:    return `CP0_INDEX;
		5'd2:    return `CP0_ENTRY_LO0;
		5'd3:    return `CP0_ENTRY_LO1;
		5'd8:    return `CP0_BADVADDR;
		5'd9:    return `CP0_COUNT;
		5'd10:   return `CP0_ENTRY_HI;
		5'd11:   return `CP0_COMPARE;
		5'd12:   return `CP0_STATUS;
		5'd13:   return `CP0_CAUSE;
		5'd14:   return `CP0_EPC;
		5'd15:   return `CP0_EBASE;
		default: return `CP0_UNIMPLEMENTED;
	endcase
endfunction

// Expected decode of one fetched word at address pc
function automatic decode_expect_t decode_expect(input logic [31:0] word,
		input logic [31:0] pc, input logic [4:0] fetch_exc, input logic in_slot,
		input logic [31:0][31:0] shadow);
	decode_expect_t e;
	logic [5:0]  op;
	logic [5:0]  funct;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic [31:0] sext;
	logic [31:0] zext;
	logic [31:0] pc4;
	logic [32:0] rel;
	logic [32:0] region;
	e = bubble_expect();
	if (fetch_exc != `EC_NONE) begin    // Fetch fault passes straight through
		e.id.exc_code     = fetch_exc;
		e.id.exc_epc      = pc;
		e.id.exc_badvaddr = pc;
		return e;
	end
	op     = word[31:26];
	rs     = word[25:21];
	rt     = word[20:16];
	rd     = word[15:11];
	funct  = word[5:0];
	rs_val = (rs == 5'd0) ? 32'h0 : shadow[rs];
	rt_val = (rt == 5'd0) ? 32'h0 : shadow[rt];
	sext   = {{16{word[15]}}, word[15:0]};
	zext   = {16'h0, word[15:0]};
	pc4    = pc + 32'd4;
	rel    = {1'b0, pc4 + {sext[29:0], 2'b00}};
	region = {1'b0, pc4[31:28], word[25:0], 2'b00};
	e.id.exc_epc = in_slot ? pc - 32'd4 : pc;    // Delay slot reports the branch
	case (op)
		`OPC_SPECIAL: begin
			if (funct == `FUNCT_SYSCALL) begin
				e.id.exc_code = `EC_SYS;
			end else if (funct == `FUNCT_JR || funct == `FUNCT_JALR) begin
				e.id.branch_opt  = `BRANCH_UNCOND;
				e.id.branch_dest = {1'b1, 32'h0};
				e.op2            = {rs, rs_val};
				if (funct == `FUNCT_JALR) begin
					e.id.branch_dest = {1'b1, region[31:0]};
					e.op1.data       = pc + 32'd8;
					e.id.alu_opt     = `ALU_OPT_PASS_OPR1;
					e.id.wb_reg_addr = rd;
				end
			end else begin
				e.id.alu_opt     = funct;
				e.id.alu_sa_imm  = {27'h0, word[10:6]};
				e.id.wb_reg_addr = rd;
				e.op1            = {rs, rs_val};
				e.op2            = {rt, rt_val};
			end
		end
		`OPC_J, `OPC_JAL: begin
			e.id.branch_opt  = `BRANCH_UNCOND;
			e.id.branch_dest = region;
			if (op == `OPC_JAL) begin
				e.op1.data       = pc + 32'd8;    // Link address
				e.id.alu_opt     = `ALU_OPT_PASS_OPR1;
				e.id.wb_reg_addr = 5'd31;
			end
		end
		`OPC_BEQ, `OPC_BNE: begin
			e.op1            = {rs, rs_val};
			e.op2            = {rt, rt_val};
			e.id.alu_opt     = `ALU_OPT_XOR;
			e.id.branch_opt  = (op == `OPC_BEQ) ? `BRANCH_ON_ALU_EQZ : `BRANCH_ON_ALU_NEZ;
			e.id.branch_dest = rel;
		end
		`OPC_BLEZ, `OPC_BGTZ: begin
			if (rt != 5'd0) begin
				e.id.exc_code = `EC_RI;
			end else begin
				e.op2            = {rs, rs_val};    // Zero less than rs
				e.id.alu_opt     = `ALU_OPT_LT;
				e.id.branch_opt  = (op == `OPC_BLEZ) ? `BRANCH_ON_ALU_EQZ : `BRANCH_ON_ALU_NEZ;
				e.id.branch_dest = rel;
			end
		end
		`OPC_REGIMM: begin
			if (rt == `RT_BLTZ || rt == `RT_BGEZ) begin
				e.op1            = {rs, rs_val};
				e.id.alu_opt     = `ALU_OPT_LT;
				e.id.branch_opt  = (rt == `RT_BGEZ) ? `BRANCH_ON_ALU_EQZ : `BRANCH_ON_ALU_NEZ;
				e.id.branch_dest = rel;
			end else begin
				e.id.exc_code = `EC_RI;
			end
		end
		`OPC_ADDIU, `OPC_SLTI, `OPC_SLTIU, `OPC_ANDI, `OPC_ORI, `OPC_XORI, `OPC_LUI: begin
			e.id.wb_reg_addr = rt;
			e.id.alu_src     = `ALU_SRC_IMM;
			e.op1            = {rs, rs_val};
			case (op)
				`OPC_ADDIU: e.id.alu_opt = `ALU_OPT_ADDU;
				`OPC_SLTI:  e.id.alu_opt = `ALU_OPT_LT;
				`OPC_SLTIU: e.id.alu_opt = `ALU_OPT_LTU;
				`OPC_ANDI:  e.id.alu_opt = `ALU_OPT_AND;
				`OPC_ORI:   e.id.alu_opt = `ALU_OPT_OR;
				`OPC_XORI:  e.id.alu_opt = `ALU_OPT_XOR;
				default:    e.id.alu_opt = `ALU_OPT_SETU;
			endcase
			// Unsigned compare still takes a sign-extended immediate
			if (op == `OPC_ADDIU || op == `OPC_SLTI || op == `OPC_SLTIU) begin
				e.id.alu_sa_imm = sext;
			end else if (op == `OPC_LUI) begin
				e.id.alu_sa_imm = {word[15:0], 16'h0};
			end else begin
				e.id.alu_sa_imm = zext;
			end
		end
		`OPC_LW, `OPC_SW: begin
			e.op1           = {rs, rs_val};
			e.op2           = {rt, rt_val};
			e.id.alu_src    = `ALU_SRC_IMM;
			e.id.alu_opt    = `ALU_OPT_ADDU;
			e.id.alu_sa_imm = sext;
			e.id.mem_opt    = (op == `OPC_LW) ? `MEM_OPT_LW : `MEM_OPT_SW;
			if (op == `OPC_LW) begin
				e.id.wb_reg_addr = rt;
			end
		end
		`OPC_COP0: begin
			if (funct == `FUNCT_ERET) begin
				e.id.exc_code = `EC_ERET;
			end else if (rs == `CP0_RS_MF || rs == `CP0_RS_MT) begin
				e.op1.data   = {28'h0, cp0_number(rd)};
				e.id.alu_opt = `ALU_OPT_PASS_OPR1;
				if (rs == `CP0_RS_MF) begin
					e.id.mem_opt     = `MEM_OPT_READ_CP0;
					e.id.wb_reg_addr = rt;
				end else begin
					e.id.mem_opt = `MEM_OPT_WRITE_CP0;
					e.op2        = {rt, rt_val};
				end
			end else begin
				e.id.exc_code = `EC_RI;
			end
		end
		default: e.id.exc_code = `EC_RI;
	endcase
	return e;
endfunction

`endif

// File: dv/tb_decode_core.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module tb_decode_core;

	localparam int RESET_CYCLES = 3;
	localparam int FILL_CYCLES  = 32;
	localparam int PROG_CYCLES  = 60;
	localparam int CYCLE_LIMIT  = 2 * (RESET_CYCLES + FILL_CYCLES + PROG_CYCLES) + 100;
	localparam int IMEM_WORDS   = 64;
	localparam int CHECK_W      = $bits(mips_pkg::id2ex_t);

	`include "decode_model.svh"

	logic                   clk;
	logic                   rst;
	logic                   stall;
	logic                   clear;
	logic                   redirect;
	logic [31:0]            redirect_target;
	logic [31:0]            imem_addr;
	logic [31:0]            imem_data;
	logic [4:0]             reg_write_addr;
	logic [31:0]            reg_write_data;
	mips_pkg::reg_operand_t op1;
	mips_pkg::reg_operand_t op2;
	mips_pkg::id2ex_t       id2ex;

	logic [31:0]       imem [IMEM_WORDS];
	logic [31:0]       lfsr_state;
	logic [31:0][31:0] shadow;       // Register file contents as seen by the TB
	logic [31:0]       exp_pc;
	logic [31:0]       fe_word;      // Expected if2id word and its address
	logic [31:0]       fe_addr;
	logic [4:0]        fe_exc;
	decode_expect_t    expected;
	int                errors;
	int                checks;
	int                cycles = 0;
	string             test_name;

	decode_core dut (
		.clk             (clk),
		.rst             (rst),
		.stall           (stall),
		.clear           (clear),
		.redirect        (redirect),
		.redirect_target (redirect_target),
		.imem_addr       (imem_addr),
		.imem_data       (imem_data),
		.reg_write_addr  (reg_write_addr),
		.reg_write_data  (reg_write_data),
		.op1             (op1),
		.op2             (op2),
		.id2ex           (id2ex)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Unused words decode as a reserved opcode
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return {6'h3f, addr[25:0] ^ addr[31:6]};
	endfunction

	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		if (addr < 32'(IMEM_WORDS * 4)) begin
			return imem[addr[7:2]];
		end
		return fill_word(addr);
	endfunction

	assign imem_data = fetch_word(imem_addr);

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h8020_0003;
		end
		return state >> 1;
	endfunction

	task automatic take_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			value      = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic logic [31:0] encode_r(input logic [5:0] op, input logic [4:0] rs, rt,
			rd, sa, input logic [5:0] funct);
		return {op, rs, rt, rd, sa, funct};
	endfunction

	function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs, rt,
			input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] encode_j(input logic [5:0] op, input logic [25:0] target);
		return {op, target};
	endfunction

	task automatic load_program();
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = fill_word(32'(i * 4));
		end
		imem[0]  = encode_r(`OPC_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, 6'h21);    // ADDU
		imem[1]  = encode_r(`OPC_SPECIAL, 5'd0, 5'd5, 5'd4, 5'd7, 6'h00);    // SLL
		imem[2]  = encode_i(`OPC_ADDIU, 5'd7, 5'd6, 16'hfffb);
		imem[3]  = encode_i(`OPC_SLTI, 5'd9, 5'd8, 16'h8001);
		imem[4]  = encode_i(`OPC_SLTIU, 5'd11, 5'd10, 16'h8001);
		imem[5]  = encode_i(`OPC_ANDI, 5'd13, 5'd12, 16'hf0f0);
		imem[6]  = encode_i(`OPC_ORI, 5'd0, 5'd14, 16'h1234);
		imem[7]  = encode_i(`OPC_XORI, 5'd16, 5'd15, 16'hffff);
		imem[8]  = encode_i(`OPC_LUI, 5'd0, 5'd17, 16'habcd);
		imem[9]  = encode_i(`OPC_LW, 5'd19, 5'd18, 16'hfff8);
		imem[10] = encode_i(`OPC_SW, 5'd21, 5'd20, 16'h000c);
		imem[11] = encode_r(`OPC_COP0, `CP0_RS_MF, 5'd22, 5'd12, 5'd0, 6'h00);
		imem[12] = encode_r(`OPC_COP0, `CP0_RS_MT, 5'd23, 5'd14, 5'd0, 6'h00);
		imem[13] = encode_r(`OPC_COP0, `CP0_RS_MF, 5'd24, 5'd5, 5'd0, 6'h00);
		imem[14] = encode_r(`OPC_COP0, 5'h10, 5'd0, 5'd0, 5'd0, `FUNCT_ERET);
		imem[15] = encode_r(`OPC_SPECIAL, 5'd0, 5'd0, 5'd0, 5'd0, `FUNCT_SYSCALL);
		imem[16] = encode_i(6'h3e, 5'd1, 5'd2, 16'h1111);
		imem[17] = encode_i(`OPC_BEQ, 5'd1, 5'd2, 16'h0003);
		imem[18] = encode_r(`OPC_SPECIAL, 5'd4, 5'd5, 5'd6, 5'd0, 6'h21);    // Delay slot
		imem[19] = encode_i(`OPC_BNE, 5'd3, 5'd4, 16'hfffe);
		imem[20] = encode_i(`OPC_BLEZ, 5'd5, 5'd0, 16'h0004);
		imem[21] = encode_i(`OPC_BGTZ, 5'd6, 5'd0, 16'h0005);
		imem[22] = encode_i(`OPC_REGIMM, 5'd7, `RT_BLTZ, 16'hffff);
		imem[23] = encode_i(`OPC_REGIMM, 5'd8, `RT_BGEZ, 16'h0002);
		imem[24] = encode_j(`OPC_J, 26'h0123456);
		imem[25] = encode_j(`OPC_JAL, 26'h0000040);
		imem[26] = encode_r(`OPC_SPECIAL, 5'd9, 5'd0, 5'd0, 5'd0, `FUNCT_JR);
		imem[27] = encode_r(`OPC_SPECIAL, 5'd10, 5'd0, 5'd30, 5'd0, `FUNCT_JALR);
		imem[28] = encode_i(`OPC_ADDIU, 5'd1, 5'd2, 16'h0001);
		imem[29] = encode_i(`OPC_BLEZ, 5'd3, 5'd4, 16'h0010);      // Nonzero rt
		imem[30] = encode_i(`OPC_REGIMM, 5'd5, 5'h05, 16'h0000);
		imem[31] = encode_r(`OPC_COP0, 5'h02, 5'd1, 5'd2, 5'd0, 6'h00);
	endtask

	task automatic check_value(input string what, input logic [CHECK_W-1:0] exp_v,
			input logic [CHECK_W-1:0] act_v);
		checks++;
		assert (act_v === exp_v) else begin
			errors++;
			$display("FAILED %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
		end
	endtask

	task automatic compare_outputs();
		check_value("imem_addr", CHECK_W'(exp_pc), CHECK_W'(imem_addr));
		check_value("id2ex", expected.id, id2ex);
		check_value("op1", CHECK_W'(expected.op1), CHECK_W'(op1));
		check_value("op2", CHECK_W'(expected.op2), CHECK_W'(op2));
	endtask

	// Drive one cycle of inputs, advance the expected pipeline, then check
	task automatic run_cycle(input logic stall_v, input logic clear_v, input logic redirect_v,
			input logic [31:0] target_v, input logic [4:0] waddr_v);
		logic [31:0] wdata_v;
		take_bits(32, wdata_v);
		stall           = stall_v;
		clear           = clear_v;
		redirect        = redirect_v;
		redirect_target = target_v;
		reg_write_addr  = waddr_v;
		reg_write_data  = wdata_v;
		if (!stall_v) begin
			if (clear_v) begin
				expected = bubble_expect();
			end else begin
				expected = decode_expect(fe_word, fe_addr, fe_exc,
					expected.id.branch_opt != `BRANCH_NONE, shadow);
			end
			if (exp_pc[1:0] != 2'b00) begin
				fe_word = '0;
				fe_exc  = `EC_ADEL;
			end else begin
				fe_word = fetch_word(exp_pc);
				fe_exc  = `EC_NONE;
			end
			fe_addr = exp_pc;
			exp_pc  = redirect_v ? target_v : exp_pc + 32'd4;
		end
		if (waddr_v != 5'd0) begin
			shadow[waddr_v] = wdata_v;    // Written at the edge, read after it
		end
		@(posedge clk);
		#1;
		compare_outputs();
	endtask

	function automatic string phase_name(input int k);
		if (k < 10) return "alu";
		if (k < 13) return "stall";
		if (k < 20) return "memory and cp0";
		if (k < 22) return "clear";
		if (k < 40) return "branch and jump";
		if (k < 46) return "misaligned redirect";
		return "stall and clear";
	endfunction

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial begin
		rst             = 1'b1;
		stall           = 1'b0;
		clear           = 1'b0;
		redirect        = 1'b0;
		redirect_target = '0;
		reg_write_addr  = '0;
		reg_write_data  = '0;
		lfsr_state      = 32'hea28;
		shadow          = '0;
		errors          = 0;
		checks          = 0;
		load_program();
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst      = 1'b0;
		exp_pc   = `MIPS_RESET_PC;
		fe_word  = '0;
		fe_addr  = `MIPS_RESET_PC;
		fe_exc   = `EC_NONE;
		expected = bubble_expect();
		test_name = "reset";
		compare_outputs();

		// Front end frozen while the register file fills
		test_name = "register fill";
		for (int i = 0; i < FILL_CYCLES; i++) begin
			run_cycle(1'b1, 1'b0, 1'b0, '0, 5'(i));
		end

		for (int k = 0; k < PROG_CYCLES; k++) begin
			test_name = phase_name(k);
			case (k)
				10, 11, 12: run_cycle(1'b1, 1'b0, 1'b0, '0, 5'd0);
				20:         run_cycle(1'b0, 1'b1, 1'b0, '0, 5'd0);
				30:         run_cycle(1'b0, 1'b0, 1'b0, '0, 5'd1);
				40:         run_cycle(1'b0, 1'b0, 1'b1, 32'h0000_0102, 5'd0);
				43:         run_cycle(1'b0, 1'b0, 1'b1, 32'h0000_0044, 5'd0);
				46:         run_cycle(1'b1, 1'b1, 1'b0, '0, 5'd0);
				47:         run_cycle(1'b1, 1'b0, 1'b1, 32'h0000_0010, 5'd0);    // Stall wins
				default:    run_cycle(1'b0, 1'b0, 1'b0, '0, 5'd0);
			endcase
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: hdl/decode_core.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module decode_core (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       stall,
	input  logic                       clear,
	input  logic                       redirect,
	input  logic [`MIPS_XLEN-1:0]      redirect_target,
	output logic [`MIPS_XLEN-1:0]      imem_addr,
	input  logic [`MIPS_XLEN-1:0]      imem_data,
	input  logic [`MIPS_REGADDR_W-1:0] reg_write_addr,
	input  logic [`MIPS_XLEN-1:0]      reg_write_data,
	output mips_pkg::reg_operand_t     op1,
	output mips_pkg::reg_operand_t     op2,
	output mips_pkg::id2ex_t           id2ex
);

	mips_pkg::if2id_t if2id;

	instr_fetch u_fetch (
		.clk             (clk),
		.rst             (rst),
		.stall           (stall),
		.redirect        (redirect),
		.redirect_target (redirect_target),
		.imem_addr       (imem_addr),
		.imem_data       (imem_data),
		.if2id           (if2id)
	);

	// Decode also owns the register file
	stage_id u_decode (
		.clk            (clk),
		.rst            (rst),
		.stall          (stall),
		.clear          (clear),
		.if2id          (if2id),
		.reg_write_addr (reg_write_addr),
		.reg_write_data (reg_write_data),
		.op1            (op1),
		.op2            (op2),
		.id2ex          (id2ex)
	);

endmodule

// File: hdl/instr_fetch.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module instr_fetch (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  stall,
	input  logic                  redirect,
	input  logic [`MIPS_XLEN-1:0] redirect_target,
	output logic [`MIPS_XLEN-1:0] imem_addr,
	input  logic [`MIPS_XLEN-1:0] imem_data,
	output mips_pkg::if2id_t      if2id
);

	logic [`MIPS_XLEN-1:0] pc;
	logic [`MIPS_XLEN-1:0] pc_plus4;
	logic                  misaligned;

	// Registered packet, control and payload kept apart
	logic [`MIPS_XLEN-1:0] fetched_instr;
	logic [`MIPS_EC_W-1:0] fetched_exc;
	logic [`MIPS_XLEN-1:0] fetched_next_pc;
	logic [`MIPS_XLEN-1:0] fetched_exc_addr;

	assign imem_addr  = pc;
	assign pc_plus4   = pc + 32'd4;
	assign misaligned = |pc[1:0];    // Word fetch only

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `MIPS_RESET_PC;
		end else if (!stall) begin
			pc <= redirect ? redirect_target : pc_plus4;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			fetched_instr <= '0;
			fetched_exc   <= `EC_NONE;
		end else if (!stall) begin
			if (misaligned) begin
				// Memory word ignored, packet becomes an address error
				fetched_instr <= '0;
				fetched_exc   <= `EC_ADEL;
			end else begin
				fetched_instr <= imem_data;
				fetched_exc   <= `EC_NONE;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			fetched_next_pc  <= pc_plus4;
			fetched_exc_addr <= pc;    // Faulting address
		end
	end

	always_comb begin
		if2id.instr    = fetched_instr;
		if2id.next_pc  = fetched_next_pc;
		if2id.exc_code = fetched_exc;
		if2id.exc_addr = fetched_exc_addr;
	end

endmodule

// File: hdl/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Datapath and instruction field widths
`define MIPS_XLEN         32
`define MIPS_REGADDR_W    5
`define MIPS_OPCODE_W     6
`define MIPS_FUNCT_W      6
`define MIPS_SA_W         5
`define MIPS_IMM_W        16
`define MIPS_JTARGET_W    26
`define MIPS_RESET_PC     32'h0000_0000

// Primary opcodes
`define OPC_SPECIAL       6'h00
`define OPC_REGIMM        6'h01
`define OPC_J             6'h02
`define OPC_JAL           6'h03
`define OPC_BEQ           6'h04
`define OPC_BNE           6'h05
`define OPC_BLEZ          6'h06
`define OPC_BGTZ          6'h07
`define OPC_ADDIU         6'h09
`define OPC_SLTI          6'h0a
`define OPC_SLTIU         6'h0b
`define OPC_ANDI          6'h0c
`define OPC_ORI           6'h0d
`define OPC_XORI          6'h0e
`define OPC_LUI           6'h0f
`define OPC_COP0          6'h10
`define OPC_LW            6'h23
`define OPC_SW            6'h2b

// Sub-decode fields
`define FUNCT_JR          6'h08
`define FUNCT_JALR        6'h09
`define FUNCT_SYSCALL     6'h0c
`define FUNCT_ERET        6'h18
`define RT_BLTZ           5'h00
`define RT_BGEZ           5'h01
`define CP0_RS_MF         5'h00
`define CP0_RS_MT         5'h04

// ALU ops beyond the R-type function codes
`define MIPS_ALU_OPT_W    6
`define ALU_OPT_ADDU      6'h37
`define ALU_OPT_LT        6'h38
`define ALU_OPT_LTU       6'h39
`define ALU_OPT_AND       6'h3a
`define ALU_OPT_OR        6'h3b
`define ALU_OPT_XOR       6'h3c
`define ALU_OPT_SETU      6'h3d
`define ALU_OPT_PASS_OPR1 6'h3e
`define ALU_OPT_DISABLE   6'h3f
`define ALU_SRC_REG       1'b0
`define ALU_SRC_IMM       1'b1

`define MIPS_MEM_OPT_W    3
`define MEM_OPT_NONE      3'd0
`define MEM_OPT_LW        3'd1
`define MEM_OPT_SW        3'd2
`define MEM_OPT_READ_CP0  3'd3
`define MEM_OPT_WRITE_CP0 3'd4
`define MEM_OPT_IS_READ(opt) ((opt) == `MEM_OPT_LW)

`define MIPS_BRANCH_OPT_W 2
`define BRANCH_NONE       2'd0
`define BRANCH_UNCOND     2'd1
`define BRANCH_ON_ALU_EQZ 2'd2
`define BRANCH_ON_ALU_NEZ 2'd3

`define MIPS_EC_W         5
`define EC_NONE           5'd0
`define EC_ADEL           5'd4
`define EC_SYS            5'd8
`define EC_RI             5'd10
`define EC_ERET           5'd31     // Internal marker, not a cause code

// Compact CP0 register numbering
`define MIPS_CP0_REG_W    4
`define CP0_INDEX         4'd0
`define CP0_ENTRY_LO0     4'd1
`define CP0_ENTRY_LO1     4'd2
`define CP0_BADVADDR      4'd3
`define CP0_COUNT         4'd4
`define CP0_ENTRY_HI      4'd5
`define CP0_COMPARE       4'd6
`define CP0_STATUS        4'd7
`define CP0_CAUSE         4'd8
`define CP0_EPC           4'd9
`define CP0_EBASE         4'd10
`define CP0_UNIMPLEMENTED 4'd15

`endif

// File: hdl/mips_pkg.sv
`include "mips_consts.svh"

package mips_pkg;

	// Register-format view
	typedef struct packed {
		logic [`MIPS_OPCODE_W-1:0]  opcode;
		logic [`MIPS_REGADDR_W-1:0] rs;
		logic [`MIPS_REGADDR_W-1:0] rt;
		logic [`MIPS_REGADDR_W-1:0] rd;
		logic [`MIPS_SA_W-1:0]      sa;
		logic [`MIPS_FUNCT_W-1:0]   funct;
	} instr_r_t;

	// Immediate-format view, jump target is {rs, rt, imm}
	typedef struct packed {
		logic [`MIPS_OPCODE_W-1:0]  opcode;
		logic [`MIPS_REGADDR_W-1:0] rs;
		logic [`MIPS_REGADDR_W-1:0] rt;
		logic [`MIPS_IMM_W-1:0]     imm;
	} instr_i_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

	typedef struct packed {
		instr_u                 instr;
		logic [`MIPS_XLEN-1:0]  next_pc;    // Fetch PC plus 4
		logic [`MIPS_EC_W-1:0]  exc_code;
		logic [`MIPS_XLEN-1:0]  exc_addr;
	} if2id_t;

	typedef struct packed {
		logic [`MIPS_REGADDR_W-1:0] addr;
		logic [`MIPS_XLEN-1:0]      data;
	} reg_operand_t;

	typedef struct packed {
		logic [`MIPS_ALU_OPT_W-1:0]    alu_opt;
		logic                          alu_src;
		logic [`MIPS_XLEN-1:0]         alu_sa_imm;
		logic [`MIPS_REGADDR_W-1:0]    wb_reg_addr;
		logic [`MIPS_MEM_OPT_W-1:0]    mem_opt;
		logic [`MIPS_BRANCH_OPT_W-1:0] branch_opt;
		// Top bit selects operand 2 data as the target
		logic [`MIPS_XLEN:0]           branch_dest;
		logic [`MIPS_EC_W-1:0]         exc_code;
		logic [`MIPS_XLEN-1:0]         exc_epc;
		logic [`MIPS_XLEN-1:0]         exc_badvaddr;
	} id2ex_t;

endpackage

// File: hdl/register_file.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module register_file (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [`MIPS_REGADDR_W-1:0] read1_addr,
	input  logic [`MIPS_REGADDR_W-1:0] read2_addr,
	input  logic [`MIPS_REGADDR_W-1:0] write_addr,
	input  logic [`MIPS_XLEN-1:0]      data_in,
	output logic [`MIPS_XLEN-1:0]      data_out1,
	output logic [`MIPS_XLEN-1:0]      data_out2
);

	localparam int NUM_REGS = 2 ** `MIPS_REGADDR_W;

	// Register 0 has no storage
	logic [`MIPS_XLEN-1:0] regs [1:NUM_REGS-1];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (write_addr != '0) begin    // Address 0 means no write
			regs[write_addr] <= data_in;
		end
	end

	// Reads see the value before this cycle's write
	assign data_out1 = (read1_addr == '0) ? '0 : regs[read1_addr];
	assign data_out2 = (read2_addr == '0) ? '0 : regs[read2_addr];

endmodule

// File: hdl/stage_id.sv
`timescale 1ns/10ps
`include "mips_consts.svh"

module stage_id (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       stall,
	input  logic                       clear,
	input  mips_pkg::if2id_t           if2id,
	input  logic [`MIPS_REGADDR_W-1:0] reg_write_addr,
	input  logic [`MIPS_XLEN-1:0]      reg_write_data,
	output mips_pkg::reg_operand_t     op1,
	output mips_pkg::reg_operand_t     op2,
	output mips_pkg::id2ex_t           id2ex
);

	mips_pkg::instr_u                instr;
	logic [`MIPS_XLEN-1:0]           next_pc;
	logic [`MIPS_XLEN-1:0]           rf_data1;
	logic [`MIPS_XLEN-1:0]           rf_data2;
	logic [`MIPS_XLEN-1:0]           imm_sext;
	logic [`MIPS_XLEN-1:0]           imm_zext;
	logic [`MIPS_JTARGET_W-1:0]      jtarget;
	logic [`MIPS_XLEN:0]             dest_pc_rel;
	logic [`MIPS_XLEN:0]             dest_region;
	logic [`MIPS_CP0_REG_W-1:0]      cp0_regnum;
	logic                            in_delay_slot;

	assign instr    = if2id.instr;
	assign next_pc  = if2id.next_pc;
	assign imm_sext = {{(`MIPS_XLEN-`MIPS_IMM_W){instr.i.imm[`MIPS_IMM_W-1]}}, instr.i.imm};
	assign imm_zext = {{(`MIPS_XLEN-`MIPS_IMM_W){1'b0}}, instr.i.imm};
	assign jtarget  = {instr.i.rs, instr.i.rt, instr.i.imm};

	assign dest_pc_rel = {1'b0, next_pc + {imm_sext[`MIPS_XLEN-3:0], 2'b00}};
	assign dest_region = {1'b0, next_pc[`MIPS_XLEN-1 -: 4], jtarget, 2'b00};    // 256MB region

	// Last decode was a branch or jump, so this one sits in its delay slot
	assign in_delay_slot = (id2ex.branch_opt != `BRANCH_NONE);

	register_file u_regfile (
		.clk        (clk),
		.rst        (rst),
		.read1_addr (instr.r.rs),
		.read2_addr (instr.r.rt),
		.write_addr (reg_write_addr),
		.data_in    (reg_write_data),
		.data_out1  (rf_data1),
		.data_out2  (rf_data2)
	);

	always_comb begin
		case (instr.r.rd)
			5'd0:    cp0_regnum = `CP0_INDEX;
			5'd2:    cp0_regnum = `CP0_ENTRY_LO0;
			5'd3:    cp0_regnum = `CP0_ENTRY_LO1;
			5'd8:    cp0_regnum = `CP0_BADVADDR;
			5'd9:    cp0_regnum = `CP0_COUNT;
			5'd10:   cp0_regnum = `CP0_ENTRY_HI;
			5'd11:   cp0_regnum = `CP0_COMPARE;
			5'd12:   cp0_regnum = `CP0_STATUS;
			5'd13:   cp0_regnum = `CP0_CAUSE;
			5'd14:   cp0_regnum = `CP0_EPC;
			5'd15:   cp0_regnum = `CP0_EBASE;
			default: cp0_regnum = `CP0_UNIMPLEMENTED;
		endcase
	end

	task automatic assign_reg1;
		op1.addr <= instr.r.rs;
		op1.data <= rf_data1;
	endtask

	task automatic assign_reg2;
		op2.addr <= instr.r.rt;
		op2.data <= rf_data2;
	endtask

	// rs routed to the second operand
	task automatic rs_to_reg2;
		op2.addr <= instr.r.rs;
		op2.data <= rf_data1;
	endtask

	task automatic alu_from_reg(input logic [`MIPS_ALU_OPT_W-1:0] opt);
		id2ex.alu_src <= `ALU_SRC_REG;
		id2ex.alu_opt <= opt;
	endtask

	task automatic alu_from_imm(input logic [`MIPS_ALU_OPT_W-1:0] opt,
			input logic [`MIPS_XLEN-1:0] imm);
		id2ex.alu_src    <= `ALU_SRC_IMM;
		id2ex.alu_opt    <= opt;
		id2ex.alu_sa_imm <= imm;
	endtask

	task automatic proc_rtype;
		id2ex.wb_reg_addr <= instr.r.rd;
		assign_reg1();
		assign_reg2();
		id2ex.alu_sa_imm <= {{(`MIPS_XLEN-`MIPS_SA_W){1'b0}}, instr.r.sa};
		alu_from_reg(instr.r.funct);    // Function code used as ALU op
	endtask

	// Address is rs plus the offset
	task automatic mem_access(input logic [`MIPS_MEM_OPT_W-1:0] opt);
		assign_reg1();
		assign_reg2();
		alu_from_imm(`ALU_OPT_ADDU, imm_sext);
		if (`MEM_OPT_IS_READ(opt)) begin
			id2ex.wb_reg_addr <= instr.i.rt;
		end
		id2ex.mem_opt <= opt;
	endtask

	task automatic wb_with_alu_imm(input logic [`MIPS_ALU_OPT_W-1:0] opt,
			input logic [`MIPS_XLEN-1:0] imm);
		id2ex.wb_reg_addr <= instr.i.rt;
		assign_reg1();
		alu_from_imm(opt, imm);
	endtask

	task automatic proc_cond_branch(input logic set_reg,
			input logic [`MIPS_ALU_OPT_W-1:0] opt,
			input logic [`MIPS_BRANCH_OPT_W-1:0] cond);
		if (set_reg) begin
			assign_reg1();
			assign_reg2();
		end
		alu_from_reg(opt);
		id2ex.branch_opt  <= cond;
		id2ex.branch_dest <= dest_pc_rel;
	endtask

	task automatic invalid_instruction;
		id2ex.exc_code <= `EC_RI;
	endtask

	task automatic proc_itype;
		case (instr.i.opcode)
			`OPC_REGIMM: begin
				if (instr.i.rt == `RT_BGEZ) begin
					assign_reg1();    // rs < 0 is false
					proc_cond_branch(1'b0, `ALU_OPT_LT, `BRANCH_ON_ALU_EQZ);
				end else if (instr.i.rt == `RT_BLTZ) begin
					assign_reg1();
					proc_cond_branch(1'b0, `ALU_OPT_LT, `BRANCH_ON_ALU_NEZ);
				end else begin
					invalid_instruction();
				end
			end
			`OPC_BEQ: proc_cond_branch(1'b1, `ALU_OPT_XOR, `BRANCH_ON_ALU_EQZ);
			`OPC_BNE: proc_cond_branch(1'b1, `ALU_OPT_XOR, `BRANCH_ON_ALU_NEZ);
			`OPC_BLEZ, `OPC_BGTZ: begin
				if (instr.i.rt == '0) begin
					// Compare 0 < rs
					rs_to_reg2();
					proc_cond_branch(1'b0, `ALU_OPT_LT, (instr.i.opcode == `OPC_BLEZ) ?
						`BRANCH_ON_ALU_EQZ : `BRANCH_ON_ALU_NEZ);
				end else begin
					invalid_instruction();
				end
			end
			`OPC_ADDIU: wb_with_alu_imm(`ALU_OPT_ADDU, imm_sext);
			`OPC_SLTI:  wb_with_alu_imm(`ALU_OPT_LT, imm_sext);
			`OPC_SLTIU: wb_with_alu_imm(`ALU_OPT_LTU, imm_sext);
			`OPC_ANDI:  wb_with_alu_imm(`ALU_OPT_AND, imm_zext);
			`OPC_ORI:   wb_with_alu_imm(`ALU_OPT_OR, imm_zext);
			`OPC_XORI:  wb_with_alu_imm(`ALU_OPT_XOR, imm_zext);
			`OPC_LUI:   wb_with_alu_imm(`ALU_OPT_SETU, {instr.i.imm, 16'h0000});
			`OPC_LW:    mem_access(`MEM_OPT_LW);
			`OPC_SW:    mem_access(`MEM_OPT_SW);
			default:    invalid_instruction();
		endcase
	endtask

	task automatic proc_instr_j;
		id2ex.branch_opt  <= `BRANCH_UNCOND;
		id2ex.branch_dest <= dest_region;
	endtask

	task automatic proc_instr_jr;
		id2ex.branch_opt     <= `BRANCH_UNCOND;
		id2ex.branch_dest[`MIPS_XLEN] <= 1'b1;    // Target from operand 2
		rs_to_reg2();
	endtask

	// Link value passes through the ALU
	task automatic proc_instr_jal;
		proc_instr_j();
		op1.data          <= next_pc + 32'd4;
		id2ex.alu_opt     <= `ALU_OPT_PASS_OPR1;
		id2ex.wb_reg_addr <= 5'd31;
	endtask

	task automatic proc_instr_jalr;
		proc_instr_jal();
		proc_instr_jr();
		id2ex.wb_reg_addr <= instr.r.rd;
	endtask

	task automatic proc_cp0;
		if (instr.r.funct == `FUNCT_ERET) begin
			id2ex.exc_code <= `EC_ERET;
		end else if (instr.r.rs == `CP0_RS_MF) begin
			id2ex.mem_opt     <= `MEM_OPT_READ_CP0;
			op1.data          <= {{(`MIPS_XLEN-`MIPS_CP0_REG_W){1'b0}}, cp0_regnum};
			id2ex.alu_opt     <= `ALU_OPT_PASS_OPR1;
			id2ex.wb_reg_addr <= instr.r.rt;
		end else if (instr.r.rs == `CP0_RS_MT) begin
			id2ex.mem_opt <= `MEM_OPT_WRITE_CP0;
			op1.data      <= {{(`MIPS_XLEN-`MIPS_CP0_REG_W){1'b0}}, cp0_regnum};
			assign_reg2();    // Value to write
			id2ex.alu_opt <= `ALU_OPT_PASS_OPR1;
		end else begin
			invalid_instruction();
		end
	endtask

	task automatic set_bubble;
		id2ex.alu_opt      <= `ALU_OPT_DISABLE;
		id2ex.alu_src      <= `ALU_SRC_REG;
		id2ex.alu_sa_imm   <= '0;
		id2ex.wb_reg_addr  <= '0;
		id2ex.mem_opt      <= `MEM_OPT_NONE;
		id2ex.branch_opt   <= `BRANCH_NONE;
		id2ex.branch_dest  <= '0;
		id2ex.exc_code     <= `EC_NONE;
		id2ex.exc_epc      <= '0;
		id2ex.exc_badvaddr <= '0;
		op1 <= '0;
		op2 <= '0;
	endtask

	task automatic do_decode;
		case (instr.r.opcode)
			`OPC_SPECIAL: begin
				case (instr.r.funct)
					`FUNCT_JR:      proc_instr_jr();
					`FUNCT_JALR:    proc_instr_jalr();
					`FUNCT_SYSCALL: id2ex.exc_code <= `EC_SYS;
					default:        proc_rtype();
				endcase
			end
			`OPC_J:    proc_instr_j();
			`OPC_JAL:  proc_instr_jal();
			`OPC_COP0: proc_cp0();
			default:   proc_itype();
		endcase
	endtask

	// Later assignments in the same edge override the bubble defaults
	always_ff @(posedge clk) begin
		if (rst) begin
			set_bubble();
		end else if (!stall) begin
			set_bubble();
			if (!clear) begin
				if (if2id.exc_code != `EC_NONE) begin
					id2ex.exc_code     <= if2id.exc_code;
					id2ex.exc_epc      <= if2id.exc_addr;
					id2ex.exc_badvaddr <= if2id.exc_addr;
				end else begin
					id2ex.exc_epc <= in_delay_slot ? next_pc - 32'd8 : next_pc - 32'd4;
					do_decode();
				end
			end
		end
	end

endmodule

// File: project.f
+incdir+hdl
+incdir+dv
hdl/mips_pkg.sv
hdl/register_file.sv
hdl/instr_fetch.sv
hdl/stage_id.sv
hdl/decode_core.sv
dv/tb_decode_core.sv

// File: run.sh
#!/bin/sh
# Build and run the decode front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/sim_decode_core

rm -rf obj_dir

verilator --binary --timing --assert -f project.f --top-module tb_decode_core \
	-o sim_decode_core
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -F -q "*** TEST PASSED ***" "$LOG"; then
	echo "Simulation passed"
	exit 0
fi

echo "Simulation failed, see $LOG"
exit 1
